// File: rtl/ocpPkg.sv
package ocpPkg;

  // Bus widths
  localparam int AddrWidth     = 64;
  localparam int DataWidth     = 32;
  localparam int ByteEnWidth   = DataWidth / 8;
  localparam int BurstLenWidth = 10;

  // Address step per INCR beat
  localparam int BeatBytes = 4;

  // MCmd encoding, only Idle, Wr and Rd are issued
  typedef enum logic [2:0] {
    CmdIdle = 3'b000,
    CmdWr   = 3'b001,
    CmdRd   = 3'b010,
    CmdRdEx = 3'b011,
    CmdRdL  = 3'b100,
    CmdWrNp = 3'b101,
    CmdWrC  = 3'b110,
    CmdBcst = 3'b111
  } ocpCmdE;

  // SResp encoding
  typedef enum logic [1:0] {
    RespNull = 2'b00,
    RespDva  = 2'b01,
    RespFail = 2'b10,
    RespErr  = 2'b11
  } ocpRespE;

  // One beat offered by the bridge
  typedef struct packed {
    logic                     read;
    logic [AddrWidth-1:0]     baseAddr;
    logic [BurstLenWidth-1:0] burstLen;
    logic [ByteEnWidth-1:0]   byteEn;
    logic [DataWidth-1:0]     wrData;
  } bridgeCmdT;

  // OCP request group
  typedef struct packed {
    ocpCmdE                   cmd;
    logic [AddrWidth-1:0]     addr;
    logic [DataWidth-1:0]     data;
    logic [ByteEnWidth-1:0]   byteEn;
    logic [BurstLenWidth-1:0] burstLen;
    logic                     reqLast;
  } ocpReqT;

  // OCP response group
  typedef struct packed {
    ocpRespE              resp;
    logic [DataWidth-1:0] data;
  } ocpRespT;

  // Response handed back to the bridge
  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic                 failed;
  } bridgeRspT;

endpackage

// File: rtl/reqSequencer.sv
`timescale 1ns/1ps

module reqSequencer (
  input  logic              Clk,
  input  logic              reset,
  input  logic              cmdReq,
  input  ocpPkg::bridgeCmdT cmd,
  output logic              cmdAck,
  output ocpPkg::ocpReqT    ocpReq,
  input  logic              SCmdAccept
);

  // Command handshake states
  typedef enum logic [1:0] {
    SeqIdle  = 2'b00,
    SeqIssue = 2'b01,
    SeqAck   = 2'b10
  } seqStateE;

  seqStateE state;

  // Beat position inside the current burst
  logic [ocpPkg::BurstLenWidth-1:0] beatCount;

  // Next beat, derived from the offered command
  logic [ocpPkg::AddrWidth-1:0] beatAddr;
  logic                         beatLast;

  // Handshake events
  logic startBeat;
  logic reqAccepted;

  // Registered request fields
  ocpPkg::ocpCmdE                   reqCmd;
  logic [ocpPkg::AddrWidth-1:0]     reqAddr;
  logic [ocpPkg::DataWidth-1:0]     reqData;
  logic [ocpPkg::ByteEnWidth-1:0]   reqByteEn;
  logic [ocpPkg::BurstLenWidth-1:0] reqBurstLen;
  logic                             reqLast;

  // New beat only from idle with the previous ack released
  assign startBeat   = (state == SeqIdle) && cmdReq && !cmdAck;
  assign reqAccepted = (state == SeqIssue) && SCmdAccept;

  // INCR address: base plus count times beat size
  assign beatAddr = cmd.baseAddr +
                    (ocpPkg::AddrWidth'(beatCount) * ocpPkg::AddrWidth'(ocpPkg::BeatBytes));

  // Last beat of the burst
  assign beatLast = (beatCount == (cmd.burstLen - ocpPkg::BurstLenWidth'(1)));

  // FSM, MCmd, ack and beat counter
  always_ff @(posedge Clk) begin
    if (reset) begin
      state     <= SeqIdle;
      reqCmd    <= ocpPkg::CmdIdle;
      cmdAck    <= 1'b0;
      beatCount <= '0;
    end else begin
      case (state)
        SeqIdle: begin
          if (startBeat) begin
            reqCmd <= cmd.read ? ocpPkg::CmdRd : ocpPkg::CmdWr;
            state  <= SeqIssue;
          end
        end

        SeqIssue: begin
          // Request held until the slave takes it
          if (reqAccepted) begin
            reqCmd <= ocpPkg::CmdIdle;
            cmdAck <= 1'b1;
            state  <= SeqAck;
            // Wrap the counter after the last beat
            if (reqLast) begin
              beatCount <= '0;
            end else begin
              beatCount <= beatCount + ocpPkg::BurstLenWidth'(1);
            end
          end
        end

        SeqAck: begin
          // Wait for the bridge to drop its request
          if (!cmdReq) begin
            cmdAck <= 1'b0;
            state  <= SeqIdle;
          end
        end

        default: begin
          state <= SeqIdle;
        end
      endcase
    end
  end

  // Request payload, loaded once per beat
  always_ff @(posedge Clk) begin
    if (startBeat) begin
      reqAddr     <= beatAddr;
      reqByteEn   <= cmd.byteEn;
      reqBurstLen <= cmd.burstLen;
      reqLast     <= beatLast;
      // Reads carry no data
      reqData     <= cmd.read ? '0 : cmd.wrData;
    end
  end

  // OCP request group
  assign ocpReq.cmd      = reqCmd;
  assign ocpReq.addr     = reqAddr;
  assign ocpReq.data     = reqData;
  assign ocpReq.byteEn   = reqByteEn;
  assign ocpReq.burstLen = reqBurstLen;
  assign ocpReq.reqLast  = reqLast;

endmodule

// File: rtl/respCapture.sv
`timescale 1ns/1ps

module respCapture (
  input  logic              Clk,
  input  logic              reset,
  input  ocpPkg::ocpRespT   ocpResp,
  output logic              MRespAccept,
  output logic              rspReq,
  output ocpPkg::bridgeRspT rsp,
  input  logic              rspAck
);

  // Decoded response
  logic [ocpPkg::DataWidth-1:0] capData;
  logic                         capFailed;

  // Response phase ends on this edge
  logic respTaken;

  // Accept only while the hold register is free
  assign respTaken = (ocpResp.resp != ocpPkg::RespNull) && MRespAccept;

  // SResp decode
  always_comb begin
    capData   = '0;
    capFailed = 1'b0;
    case (ocpResp.resp)
      ocpPkg::RespDva: begin
        capData = ocpResp.data;
      end
      ocpPkg::RespFail: begin
        // Data still valid on Fail
        capData   = ocpResp.data;
        capFailed = 1'b1;
      end
      ocpPkg::RespErr: begin
        capFailed = 1'b1;
      end
      default: begin
        capData   = '0;
        capFailed = 1'b0;
      end
    endcase
  end

  // Bridge handshake and back-pressure
  always_ff @(posedge Clk) begin
    if (reset) begin
      rspReq      <= 1'b0;
      MRespAccept <= 1'b1;
    end else begin
      if (respTaken) begin
        rspReq      <= 1'b1;
        MRespAccept <= 1'b0;
      end else if (rspReq && rspAck) begin
        rspReq <= 1'b0;
      end else if (!MRespAccept && !rspReq && !rspAck) begin
        // Four-phase cycle done, slot free again
        MRespAccept <= 1'b1;
      end
    end
  end

  // Hold register, stable while rspReq is high
  always_ff @(posedge Clk) begin
    if (respTaken) begin
      rsp.data   <= capData;
      rsp.failed <= capFailed;
    end
  end

endmodule

// File: rtl/ocpMaster.sv
`timescale 1ns/1ps

module ocpMaster (
  input  logic              Clk,
  input  logic              reset,

  // Bridge command channel
  input  logic              cmdReq,
  input  ocpPkg::bridgeCmdT cmd,
  output logic              cmdAck,

  // Bridge response channel
  output logic              rspReq,
  output ocpPkg::bridgeRspT rsp,
  input  logic              rspAck,

  // OCP request group
  output ocpPkg::ocpReqT    ocpReq,
  input  logic              SCmdAccept,

  // OCP response group
  input  ocpPkg::ocpRespT   ocpResp,
  output logic              MRespAccept
);

  // Request side, one beat per command handshake
  reqSequencer u_reqSequencer (
    .Clk        (Clk),
    .reset      (reset),
    .cmdReq     (cmdReq),
    .cmd        (cmd),
    .cmdAck     (cmdAck),
    .ocpReq     (ocpReq),
    .SCmdAccept (SCmdAccept)
  );

  // Response side, runs independently of the requests
  respCapture u_respCapture (
    .Clk         (Clk),
    .reset       (reset),
    .ocpResp     (ocpResp),
    .MRespAccept (MRespAccept),
    .rspReq      (rspReq),
    .rsp         (rsp),
    .rspAck      (rspAck)
  );

endmodule

// File: bench/ocpMaster_chk.sv
`timescale 1ns/1ps

module ocpMaster_chk (
  input logic              Clk,
  input logic              reset,
  input ocpPkg::ocpReqT    ocpReq,
  input logic              SCmdAccept,
  input logic              cmdAck,
  input logic              rspReq,
  input ocpPkg::bridgeRspT rsp
);

  // Failed assertions so far, added to the bench error count
  int failCount = 0;

  // Request group frozen until SCmdAccept
  reqHeld: assert property (@(posedge Clk) disable iff (reset)
    (ocpReq.cmd != ocpPkg::CmdIdle && !SCmdAccept) |=> $stable(ocpReq))
    else begin
      failCount++;
      $error("ocpReq changed while waiting for SCmdAccept");
    end

  // Ack only once the request has ended
  ackAfterReq: assert property (@(posedge Clk) disable iff (reset)
    !(cmdAck && ocpReq.cmd != ocpPkg::CmdIdle))
    else begin
      failCount++;
      $error("cmdAck high while an OCP request is valid");
    end

  // Bridge response held under rspReq
  rspHeld: assert property (@(posedge Clk) disable iff (reset)
    rspReq |=> (!rspReq || $stable(rsp)))
    else begin
      failCount++;
      $error("rsp changed while rspReq was high");
    end

endmodule

bind ocpMaster ocpMaster_chk u_ocpMasterChk (
  .Clk        (Clk),
  .reset      (reset),
  .ocpReq     (ocpReq),
  .SCmdAccept (SCmdAccept),
  .cmdAck     (cmdAck),
  .rspReq     (rspReq),
  .rsp        (rsp)
);

// File: bench/ocpMasterTb.sv
`timescale 1ns/1ps

module ocpMasterTb;

  // Run length, 15 beats over all tests
  localparam int TotalBeats     = 15;
  localparam int WatchdogCycles = TotalBeats * 40 + 200;
  localparam int AckTimeout     = 20;
  localparam int RspTimeout     = 100;

  logic              Clk;
  logic              reset;
  logic              cmdReq;
  ocpPkg::bridgeCmdT cmd;
  logic              cmdAck;
  logic              rspReq;
  ocpPkg::bridgeRspT rsp;
  logic              rspAck;
  ocpPkg::ocpReqT    ocpReq;
  logic              SCmdAccept;
  ocpPkg::ocpRespT   ocpResp;
  logic              MRespAccept;

  int errorCount  = 0;
  int checkCount  = 0;
  int cycleCount  = 0;
  int acceptCount = 0;
  int rspHoldOff  = 0;
  logic [15:0] lfsrState = 16'd35742;

  // Accepted requests, pending slave responses, delivered bridge responses
  ocpPkg::ocpReqT    reqLog[$];
  ocpPkg::ocpRespT   respPend[$];
  int                respDue[$];
  ocpPkg::bridgeRspT rspLog[$];

  ocpMaster u_ocpMaster (
    .Clk         (Clk),
    .reset       (reset),
    .cmdReq      (cmdReq),
    .cmd         (cmd),
    .cmdAck      (cmdAck),
    .rspReq      (rspReq),
    .rsp         (rsp),
    .rspAck      (rspAck),
    .ocpReq      (ocpReq),
    .SCmdAccept  (SCmdAccept),
    .ocpResp     (ocpResp),
    .MRespAccept (MRespAccept)
  );

  initial begin
    Clk = 1'b0;
    forever #2 Clk = ~Clk;
  end

  // Cycle and accept counters, read 1 ns after the edge
  always @(posedge Clk) begin
    cycleCount <= cycleCount + 1;
    if (!reset && SCmdAccept) begin
      acceptCount <= acceptCount + 1;
    end
  end

  // 16-bit Galois LFSR
  function automatic logic [15:0] lfsrNext(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
  endfunction

  // One step per bit taken
  function automatic logic [31:0] takeBits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = lfsrNext(lfsrState);
      value = {value[30:0], lfsrState[0]};
    end
    return value;
  endfunction

  // Slave read data rule
  function automatic logic [31:0] expectedReadData(input logic [63:0] addr);
    return addr[31:0] ^ 32'hA5A5_5A5A;
  endfunction

  function automatic ocpPkg::bridgeCmdT buildCommand(input logic read, input logic [63:0] base,
      input logic [9:0] len, input logic [3:0] byteEn, input logic [31:0] wrData);
    ocpPkg::bridgeCmdT beat;
    beat.read     = read;
    beat.baseAddr = base;
    beat.burstLen = len;
    beat.byteEn   = byteEn;
    beat.wrData   = wrData;
    return beat;
  endfunction

  task automatic checkValue(input string name, input logic [63:0] expected,
      input logic [63:0] actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("CHECK FAILED %s: expected %0h, got %0h at %0t", name, expected, actual, $time);
    end
  endtask

  // Slave request side, 0 to 3 cycles of SCmdAccept delay
  initial begin : slaveReqModel
    int              acceptDelay;
    ocpPkg::ocpReqT  acceptedReq;
    ocpPkg::ocpRespT respWord;
    SCmdAccept = 1'b0;
    forever begin
      @(posedge Clk);
      #1;
      if (!reset && ocpReq.cmd != ocpPkg::CmdIdle) begin
        acceptDelay = int'(takeBits(2));
        repeat (acceptDelay) begin
          @(posedge Clk);
          #1;
        end
        acceptedReq = ocpReq;
        SCmdAccept  = 1'b1;
        @(posedge Clk);
        #1;
        SCmdAccept = 1'b0;
        reqLog.push_back(acceptedReq);
        // Reads answered 1 or 2 cycles on, bit 12 marks a failing address
        if (acceptedReq.cmd == ocpPkg::CmdRd) begin
          respWord.resp = acceptedReq.addr[12] ? ocpPkg::RespFail : ocpPkg::RespDva;
          respWord.data = acceptedReq.addr[31:0] ^ 32'hA5A5_5A5A;
          respPend.push_back(respWord);
          respDue.push_back(cycleCount + 1 + int'(takeBits(1)));
        end
      end
    end
  end

  // Slave response side, held until MRespAccept is seen at an edge
  initial begin : slaveRespModel
    logic acceptBefore;
    acceptBefore = 1'b0;
    ocpResp      = '0;
    forever begin
      @(posedge Clk);
      #1;
      if (ocpResp.resp != ocpPkg::RespNull && acceptBefore) begin
        ocpResp = '0;
      end
      if (ocpResp.resp == ocpPkg::RespNull && respPend.size() > 0 &&
          respDue[0] <= cycleCount) begin
        ocpResp = respPend.pop_front();
        void'(respDue.pop_front());
      end
      // MRespAccept as it stands at the next edge
      acceptBefore = MRespAccept;
    end
  end

  // Bridge response side, optional hold-off before rspAck
  initial begin : bridgeRspModel
    ocpPkg::bridgeRspT held;
    rspAck = 1'b0;
    forever begin
      @(posedge Clk);
      #1;
      if (!reset && rspReq === 1'b1) begin
        held = rsp;
        repeat (rspHoldOff) begin
          @(posedge Clk);
          #1;
          checkValue("MRespAccept", 64'(1'b0), 64'(MRespAccept));
          checkValue("rsp", 64'(held), 64'(rsp));
        end
        rspHoldOff = 0;
        rspLog.push_back(rsp);
        rspAck = 1'b1;
        while (rspReq) begin
          @(posedge Clk);
          #1;
        end
        rspAck = 1'b0;
      end
    end
  end

  task automatic awaitCmdAck(input logic level);
    int waited;
    waited = 0;
    while (cmdAck !== level && waited < AckTimeout) begin
      @(posedge Clk);
      #1;
      waited++;
    end
    if (cmdAck !== level) begin
      errorCount++;
      $display("cmdAck did not go to %0b within %0d cycles", level, AckTimeout);
    end
  endtask

  // Bridge command side, one full four-phase cycle
  task automatic sendBeat(input ocpPkg::bridgeCmdT beat);
    int acceptsBefore;
    acceptsBefore = acceptCount;
    cmd    = beat;
    cmdReq = 1'b1;
    awaitCmdAck(1'b1);
    // Ack only after exactly one accepted request
    checkValue("acceptCount", 64'(acceptsBefore + 1), 64'(acceptCount));
    cmdReq = 1'b0;
    awaitCmdAck(1'b0);
    cmd = '0;
  endtask

  task automatic waitResponses(input int count);
    int waited;
    waited = 0;
    while (rspLog.size() < count && waited < RspTimeout) begin
      @(posedge Clk);
      #1;
      waited++;
    end
    if (rspLog.size() < count) begin
      errorCount++;
      $display("Only %0d of %0d responses reached the bridge", rspLog.size(), count);
    end
  endtask

  task automatic compareRequest(input ocpPkg::ocpCmdE expCmd, input logic [63:0] addr,
      input logic [31:0] data, input logic [3:0] byteEn, input logic [9:0] len,
      input logic last);
    ocpPkg::ocpReqT got;
    if (reqLog.size() == 0) begin
      errorCount++;
      $display("Expected an OCP request at address %0h but none was accepted", addr);
    end else begin
      got = reqLog.pop_front();
      checkValue("ocpReq.cmd", 64'(expCmd), 64'(got.cmd));
      checkValue("ocpReq.addr", addr, got.addr);
      checkValue("ocpReq.data", 64'(data), 64'(got.data));
      checkValue("ocpReq.byteEn", 64'(byteEn), 64'(got.byteEn));
      checkValue("ocpReq.burstLen", 64'(len), 64'(got.burstLen));
      checkValue("ocpReq.reqLast", 64'(last), 64'(got.reqLast));
    end
  endtask

  task automatic compareResponse(input logic [31:0] data, input logic failed);
    ocpPkg::bridgeRspT got;
    if (rspLog.size() == 0) begin
      errorCount++;
      $display("Expected a bridge response but none was delivered");
    end else begin
      got = rspLog.pop_front();
      checkValue("rsp.data", 64'(data), 64'(got.data));
      checkValue("rsp.failed", 64'(failed), 64'(got.failed));
    end
  endtask

  task automatic resetState();
    checkValue("ocpReq.cmd", 64'(ocpPkg::CmdIdle), 64'(ocpReq.cmd));
    checkValue("cmdAck", 64'(1'b0), 64'(cmdAck));
    checkValue("rspReq", 64'(1'b0), 64'(rspReq));
    checkValue("MRespAccept", 64'(1'b1), 64'(MRespAccept));
  endtask

  task automatic singleWrite();
    logic [63:0] addr;
    addr = 64'h0000_0001_2340_0010;
    sendBeat(buildCommand(1'b0, addr, 10'd1, 4'b0110, 32'hDEAD_BEEF));
    compareRequest(ocpPkg::CmdWr, addr, 32'hDEAD_BEEF, 4'b0110, 10'd1, 1'b1);
  endtask

  task automatic writeBurst();
    logic [63:0] base;
    int          k;
    base = 64'h0000_0000_8000_0100;
    for (k = 0; k < 5; k++) begin
      sendBeat(buildCommand(1'b0, base, 10'd5, 4'hF, 32'h1000_0000 + 32'(k) * 32'h0101_0101));
    end
    // INCR: beat k at base plus 4k
    for (k = 0; k < 5; k++) begin
      compareRequest(ocpPkg::CmdWr, base + 64'(4 * k), 32'h1000_0000 + 32'(k) * 32'h0101_0101,
                     4'hF, 10'd5, k == 4);
    end
  endtask

  task automatic issueReads(input logic [63:0] base, input int beats);
    int k;
    // Write data offered on reads must not reach the bus
    for (k = 0; k < beats; k++) begin
      sendBeat(buildCommand(1'b1, base, 10'(beats), 4'hF, 32'h1234_5678));
    end
    for (k = 0; k < beats; k++) begin
      compareRequest(ocpPkg::CmdRd, base + 64'(4 * k), 32'h0, 4'hF, 10'(beats), k == beats - 1);
    end
  endtask

  task automatic checkReads(input logic [63:0] base, input int beats, input logic failed);
    int k;
    waitResponses(beats);
    for (k = 0; k < beats; k++) begin
      compareResponse(expectedReadData(base + 64'(4 * k)), failed);
    end
  endtask

  task automatic readBurst(input logic [63:0] base, input int beats, input logic failed);
    issueReads(base, beats);
    checkReads(base, beats, failed);
  endtask

  task automatic responseBackPressure();
    logic [63:0] heldAddr;
    heldAddr   = 64'h0000_0000_0000_4100;
    rspHoldOff = 6;
    sendBeat(buildCommand(1'b1, heldAddr, 10'd1, 4'hF, 32'h0));
    compareRequest(ocpPkg::CmdRd, heldAddr, 32'h0, 4'hF, 10'd1, 1'b1);
    // Burst issued while the first response is still held
    issueReads(64'h0000_0000_0000_8200, 3);
    // Held response first, then the burst in order
    waitResponses(1);
    compareResponse(expectedReadData(heldAddr), 1'b0);
    checkReads(64'h0000_0000_0000_8200, 3, 1'b0);
  endtask

  initial begin
    reset  = 1'b1;
    cmdReq = 1'b0;
    cmd    = '0;
    repeat (5) @(posedge Clk);
    #1;
    reset = 1'b0;
    resetState();
    singleWrite();
    writeBurst();
    readBurst(64'h0000_0000_0000_2000, 4, 1'b0);
    // Bit 12 set, slave answers Fail
    readBurst(64'h0000_0000_0000_1040, 1, 1'b1);
    responseBackPressure();
    repeat (10) @(posedge Clk);
    errorCount += u_ocpMaster.u_ocpMasterChk.failCount;
    $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WatchdogCycles) @(posedge Clk);
    $display("Timeout: the tests did not finish within %0d cycles", WatchdogCycles);
    $display("Errors found");
    $finish;
  end

endmodule

// File: files.f
rtl/ocpPkg.sv
rtl/reqSequencer.sv
rtl/respCapture.sv
rtl/ocpMaster.sv
bench/ocpMaster_chk.sv
bench/ocpMasterTb.sv

// File: Makefile
SIM       ?= verilator
TOP       := ocpMasterTb
FILELIST  := files.f
SIM_FLAGS := --binary --timing --assert -j 0
RUN_FLAGS := +verilator+error+limit+1000
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(RUN_FLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "No errors" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
